// File: design/cache_consts.svh
//--------------------------------------------------------------------
// Geometry and address field positions of the L1 data cache
//--------------------------------------------------------------------

`ifndef CACHE_CONSTS_SVH
`define CACHE_CONSTS_SVH

// Widths
`define CACHE_ADDR_W          32
`define CACHE_WORD_W          32
`define CACHE_LINE_W          128

// Organization, two ways per set
`define CACHE_NUM_SETS        8
`define CACHE_WORDS_PER_LINE  4

// Byte address fields
`define CACHE_OFFSET_LSB      2
`define CACHE_INDEX_LSB       4
`define CACHE_TAG_LSB         7

`endif

// File: design/cache_pkg.sv
//--------------------------------------------------------------------
// Cache types: address fields, data words, lines and FSM states
//--------------------------------------------------------------------

`include "cache_consts.svh"

package cache_pkg;

  typedef logic [`CACHE_ADDR_W-1:0]                      addr_t;
  typedef logic [`CACHE_WORD_W-1:0]                      word_t;
  typedef logic [`CACHE_LINE_W-1:0]                      line_t;

  // Fields of a byte address
  typedef logic [`CACHE_ADDR_W-1:`CACHE_TAG_LSB]         tag_t;
  typedef logic [`CACHE_TAG_LSB-`CACHE_INDEX_LSB-1:0]    set_idx_t;
  typedef logic [`CACHE_INDEX_LSB-`CACHE_OFFSET_LSB-1:0] word_off_t;

  // One bit per word of a line
  typedef logic [`CACHE_WORDS_PER_LINE-1:0]              word_en_t;

  typedef enum logic [3:0] {
    IDLE, TAG_CHECK, READ_ACCESS, WRITE_ACCESS,
    REFILL_REQUEST, REFILL_WAIT, REFILL_UPDATE,
    EVICT_PREPARE, EVICT_REQUEST, EVICT_WAIT, WAIT
  } ctrl_state_t;

endpackage

// File: design/cache_ctrl.sv
//--------------------------------------------------------------------
// Cache control FSM and per-state strobes for the datapath
//--------------------------------------------------------------------

`timescale 1ns/100ps

module cache_ctrl import cache_pkg::*; (
  input  logic clk,
  input  logic reset,
  input  logic cachereq_val,
  input  logic cachereq_write,
  output logic cachereq_rdy,
  output logic cacheresp_val,
  input  logic cacheresp_rdy,
  output logic memreq_val,
  input  logic memreq_rdy,
  output logic memreq_write,
  input  logic memresp_val,
  output logic memresp_rdy,
  input  logic hit,
  input  logic victim_dirty,
  output logic cachereq_en,
  output logic tag_ren,
  output logic tag_wen,
  output logic way_record_en,
  output logic valid_wen,
  output logic dirty_wen,
  output logic dirty_bit_in,
  output logic lru_wen,
  output logic data_ren,
  output logic data_wen,
  output logic is_refill,
  output logic memresp_en,
  output logic evict_reg_en,
  output logic read_word_en,
  output logic mem_evict
);

  ctrl_state_t state;
  ctrl_state_t state_next;
  logic        req_write;

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= IDLE;
      req_write <= 1'b0;
    end else begin
      state <= state_next;
      if (cachereq_en) begin
        req_write <= cachereq_write;
      end
    end
  end

  //--------------------------------------------------------------------
  // Next state
  //--------------------------------------------------------------------

  always_comb begin
    state_next = state;
    case (state)
      IDLE:           if (cachereq_val) state_next = TAG_CHECK;
      TAG_CHECK: begin
        if (hit) begin
          state_next = req_write ? WRITE_ACCESS : READ_ACCESS;
        end else begin
          // Dirty victim goes out before the refill
          state_next = victim_dirty ? EVICT_PREPARE : REFILL_REQUEST;
        end
      end
      READ_ACCESS:    state_next = WAIT;
      WRITE_ACCESS:   state_next = WAIT;
      REFILL_REQUEST: if (memreq_rdy) state_next = REFILL_WAIT;
      REFILL_WAIT:    if (memresp_val) state_next = REFILL_UPDATE;
      REFILL_UPDATE:  state_next = req_write ? WRITE_ACCESS : READ_ACCESS;
      EVICT_PREPARE:  state_next = EVICT_REQUEST;
      EVICT_REQUEST:  if (memreq_rdy) state_next = EVICT_WAIT;
      EVICT_WAIT:     if (memresp_val) state_next = REFILL_REQUEST;
      WAIT:           if (cacheresp_rdy) state_next = IDLE;
      default:        state_next = IDLE;
    endcase
  end

  //--------------------------------------------------------------------
  // Strobes
  //--------------------------------------------------------------------

  always_comb begin
    cachereq_rdy  = (state == IDLE);
    cachereq_en   = (state == IDLE) && cachereq_val;
    cacheresp_val = (state == WAIT);
    memreq_val    = (state == REFILL_REQUEST) || (state == EVICT_REQUEST);
    memreq_write  = (state == EVICT_REQUEST);
    mem_evict     = (state == EVICT_REQUEST);
    memresp_rdy   = (state == REFILL_WAIT) || (state == EVICT_WAIT);
    memresp_en    = (state == REFILL_WAIT);
    tag_ren       = (state == TAG_CHECK);
    way_record_en = (state == TAG_CHECK);
    tag_wen       = 1'b0;
    valid_wen     = 1'b0;
    dirty_wen     = 1'b0;
    dirty_bit_in  = 1'b0;
    lru_wen       = 1'b0;
    data_ren      = 1'b0;
    data_wen      = 1'b0;
    is_refill     = 1'b0;
    evict_reg_en  = 1'b0;
    read_word_en  = 1'b0;
    case (state)
      READ_ACCESS: begin
        data_ren     = 1'b1;
        read_word_en = 1'b1;
        lru_wen      = 1'b1;
      end
      WRITE_ACCESS: begin
        // Response word is loaded with zero here
        data_wen     = 1'b1;
        dirty_wen    = 1'b1;
        dirty_bit_in = 1'b1;
        lru_wen      = 1'b1;
        read_word_en = 1'b1;
      end
      REFILL_UPDATE: begin
        tag_wen   = 1'b1;
        valid_wen = 1'b1;
        dirty_wen = 1'b1;
        data_wen  = 1'b1;
        is_refill = 1'b1;
      end
      EVICT_PREPARE: begin
        data_ren     = 1'b1;
        evict_reg_en = 1'b1;
      end
      default: ;
    endcase
  end

  // Memory request held under back-pressure
  assert property (@(posedge clk) disable iff (reset)
    memreq_val && !memreq_rdy |=> memreq_val);

endmodule

// File: design/cache_lookup.sv
//--------------------------------------------------------------------
// Request address register, tag and state bits, hit and victim logic
//--------------------------------------------------------------------

`timescale 1ns/100ps

`include "cache_consts.svh"

module cache_lookup import cache_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  logic      cachereq_en,
  input  addr_t     cachereq_addr,
  input  logic      tag_ren,
  input  logic      tag_wen,
  input  logic      way_record_en,
  input  logic      valid_wen,
  input  logic      dirty_wen,
  input  logic      dirty_bit_in,
  input  logic      lru_wen,
  input  logic      mem_evict,
  output logic      hit,
  output logic      victim_dirty,
  output logic      way_sel,
  output set_idx_t  req_idx,
  output word_off_t req_offset,
  output addr_t     memreq_addr
);

  addr_t req_addr;
  tag_t  req_tag;
  tag_t  victim_tag;
  tag_t  tag_array [2][`CACHE_NUM_SETS];
  logic [`CACHE_NUM_SETS-1:0] valid_bits [2];
  logic [`CACHE_NUM_SETS-1:0] dirty_bits [2];
  // Per set, the index of the least recently used way
  logic [`CACHE_NUM_SETS-1:0] lru_bits;
  logic [1:0] hit_way;
  logic       lru_way;

  always_ff @(posedge clk) begin
    if (cachereq_en) begin
      req_addr <= cachereq_addr;
    end
  end

  assign req_tag    = req_addr[`CACHE_ADDR_W-1:`CACHE_TAG_LSB];
  assign req_idx    = req_addr[`CACHE_TAG_LSB-1:`CACHE_INDEX_LSB];
  assign req_offset = req_addr[`CACHE_INDEX_LSB-1:`CACHE_OFFSET_LSB];

  //--------------------------------------------------------------------
  // Hit and victim detection
  //--------------------------------------------------------------------

  always_comb begin
    for (int w = 0; w < 2; w++) begin
      hit_way[w] = tag_ren && valid_bits[w][req_idx] && (tag_array[w][req_idx] == req_tag);
    end
  end

  assign hit          = |hit_way;
  assign lru_way      = lru_bits[req_idx];
  assign victim_dirty = valid_bits[lru_way][req_idx] && dirty_bits[lru_way][req_idx];

  // Hit way, or the LRU way on a miss, kept for the whole access
  always_ff @(posedge clk) begin
    if (reset) begin
      way_sel <= 1'b0;
    end else if (way_record_en) begin
      way_sel <= hit_way[1] ? 1'b1 : (hit_way[0] ? 1'b0 : lru_way);
    end
  end

  //--------------------------------------------------------------------
  // Array updates
  //--------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (tag_wen) begin
      tag_array[way_sel][req_idx] <= req_tag;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int w = 0; w < 2; w++) begin
        valid_bits[w] <= '0;
        dirty_bits[w] <= '0;
      end
      lru_bits <= '0;
    end else begin
      if (valid_wen) valid_bits[way_sel][req_idx] <= 1'b1;
      if (dirty_wen) dirty_bits[way_sel][req_idx] <= dirty_bit_in;
      if (lru_wen)   lru_bits[req_idx] <= ~way_sel;
    end
  end

  // Line aligned memory address
  assign victim_tag  = tag_array[way_sel][req_idx];
  assign memreq_addr = {mem_evict ? victim_tag : req_tag, req_idx, {`CACHE_INDEX_LSB{1'b0}}};

  assert property (@(posedge clk) disable iff (reset) !(hit_way[0] && hit_way[1]));

endmodule

// File: design/cache_data_array.sv
//--------------------------------------------------------------------
// Line storage for both ways, word enables, response and evict regs
//--------------------------------------------------------------------

`timescale 1ns/100ps

`include "cache_consts.svh"

module cache_data_array import cache_pkg::*; (
  input  logic      clk,
  input  logic      cachereq_en,
  input  word_t     cachereq_data,
  input  logic      way_sel,
  input  set_idx_t  req_idx,
  input  word_off_t req_offset,
  input  logic      data_ren,
  input  logic      data_wen,
  input  logic      is_refill,
  input  logic      memresp_en,
  input  line_t     memresp_data,
  input  logic      evict_reg_en,
  input  logic      read_word_en,
  output word_t     cacheresp_data,
  output line_t     memreq_data
);

  line_t    data_array [2][`CACHE_NUM_SETS];
  line_t    cur_line;
  line_t    refill_line;
  line_t    evict_line;
  word_t    write_word;
  word_t    cur_word;
  word_t    read_word;
  word_en_t word_en;

  always_ff @(posedge clk) begin
    if (cachereq_en) write_word  <= cachereq_data;
    if (memresp_en)  refill_line <= memresp_data;
  end

  // All words on refill, else the addressed word only
  assign word_en  = is_refill ? '1 : word_en_t'(1) << req_offset;
  assign cur_line = data_array[way_sel][req_idx];
  assign cur_word = cur_line[req_offset*`CACHE_WORD_W +: `CACHE_WORD_W];

  always_ff @(posedge clk) begin
    if (data_wen) begin
      for (int w = 0; w < `CACHE_WORDS_PER_LINE; w++) begin
        if (word_en[w]) begin
          data_array[way_sel][req_idx][w*`CACHE_WORD_W +: `CACHE_WORD_W] <=
            is_refill ? refill_line[w*`CACHE_WORD_W +: `CACHE_WORD_W] : write_word;
        end
      end
    end
  end

  //--------------------------------------------------------------------
  // Output registers
  //--------------------------------------------------------------------

  always_ff @(posedge clk) begin
    // Zero when no read is in progress, as for a write response
    if (read_word_en) read_word <= data_ren ? cur_word : '0;
    if (evict_reg_en) evict_line <= cur_line;
  end

  assign cacheresp_data = read_word;
  assign memreq_data    = evict_line;

  assert property (@(posedge clk) !(data_ren && data_wen));

endmodule

// File: design/blocking_cache.sv
//--------------------------------------------------------------------
// Blocking two-way L1 data cache top level
//--------------------------------------------------------------------

`timescale 1ns/100ps

module blocking_cache import cache_pkg::*; (
  input  logic  clk,
  input  logic  reset,
  input  logic  cachereq_val,
  output logic  cachereq_rdy,
  input  logic  cachereq_write,
  input  addr_t cachereq_addr,
  input  word_t cachereq_data,
  output logic  cacheresp_val,
  input  logic  cacheresp_rdy,
  output word_t cacheresp_data,
  output logic  memreq_val,
  input  logic  memreq_rdy,
  output logic  memreq_write,
  output addr_t memreq_addr,
  output line_t memreq_data,
  input  logic  memresp_val,
  output logic  memresp_rdy,
  input  line_t memresp_data
);

  // Control to datapath
  logic cachereq_en, tag_ren, tag_wen, way_record_en, valid_wen;
  logic dirty_wen, dirty_bit_in, lru_wen, data_ren, data_wen;
  logic is_refill, memresp_en, evict_reg_en, read_word_en, mem_evict;
  // Datapath status and shared fields
  logic      hit, victim_dirty, way_sel;
  set_idx_t  req_idx;
  word_off_t req_offset;

  cache_ctrl ctrl (
    .clk, .reset, .cachereq_val, .cachereq_write, .cachereq_rdy,
    .cacheresp_val, .cacheresp_rdy, .memreq_val, .memreq_rdy, .memreq_write,
    .memresp_val, .memresp_rdy, .hit, .victim_dirty, .cachereq_en, .tag_ren,
    .tag_wen, .way_record_en, .valid_wen, .dirty_wen, .dirty_bit_in, .lru_wen,
    .data_ren, .data_wen, .is_refill, .memresp_en, .evict_reg_en, .read_word_en,
    .mem_evict
  );

  cache_lookup lookup (
    .clk, .reset, .cachereq_en, .cachereq_addr, .tag_ren, .tag_wen,
    .way_record_en, .valid_wen, .dirty_wen, .dirty_bit_in, .lru_wen, .mem_evict,
    .hit, .victim_dirty, .way_sel, .req_idx, .req_offset, .memreq_addr
  );

  cache_data_array data (
    .clk, .cachereq_en, .cachereq_data, .way_sel, .req_idx, .req_offset,
    .data_ren, .data_wen, .is_refill, .memresp_en, .memresp_data, .evict_reg_en,
    .read_word_en, .cacheresp_data, .memreq_data
  );

endmodule

// File: verification/cache_tests.svh
//--------------------------------------------------------------------
// Directed cache tests and the request tasks they share
//--------------------------------------------------------------------

// Starts 10 ns after an edge, returns 10 ns after the accepting edge
task automatic send_request(input logic write, input addr_t addr, input word_t wdata);
  cachereq_val   = 1'b1;
  cachereq_write = write;
  cachereq_addr  = addr;
  cachereq_data  = wdata;
  do @(negedge clk); while (!cachereq_rdy);
  @(posedge clk);
  #10;
  cachereq_val = 1'b0;
endtask

// Latency counts cycles from acceptance until cacheresp_val
task automatic cache_access(input logic write, input addr_t addr, input word_t wdata,
                            output word_t rdata, output int latency);
  send_request(write, addr, wdata);
  latency = 0;
  do begin
    @(negedge clk);
    latency++;
  end while (!cacheresp_val);
  rdata = cacheresp_data;
  @(posedge clk);
  #10;
endtask

task automatic store_word(input addr_t addr, input word_t wdata);
  word_t rdata;
  int    latency;
  cache_access(1'b1, addr, wdata, rdata, latency);
  compare_value("cacheresp_data", rdata, 32'h0);
  ref_mem[addr[11:2]] = wdata;
endtask

task automatic load_word(input addr_t addr, output int latency);
  word_t rdata;
  cache_access(1'b0, addr, 32'h0, rdata, latency);
  compare_value("cacheresp_data", rdata, ref_mem[addr[11:2]]);
endtask

task automatic finish_test(input string name, input int errors_before);
  test_count++;
  $display("Test %s done with %0d errors", name, error_count - errors_before);
endtask

//--------------------------------------------------------------------
// Tests
//--------------------------------------------------------------------

task automatic reset_and_miss_test();
  int errors_before, latency;
  errors_before = error_count;
  compare_value("cachereq_rdy", cachereq_rdy, 1'b1);
  compare_value("cacheresp_val", cacheresp_val, 1'b0);
  compare_value("memreq_val", memreq_val, 1'b0);
  compare_value("memresp_rdy", memresp_rdy, 1'b0);
  load_word(32'h0000_0014, latency);
  compare_value("memory reads", rd_count, 1);
  compare_value("memory writes", wr_count, 0);
  finish_test("reset and read miss", errors_before);
endtask

task automatic write_read_hit_test();
  int errors_before, reads, writes, latency;
  errors_before = error_count;
  store_word(32'h0000_0028, 32'hdead_beef);
  reads  = rd_count;
  writes = wr_count;
  load_word(32'h0000_0028, latency);
  compare_value("hit latency", latency, 3);
  compare_value("memory reads", rd_count, reads);
  compare_value("memory writes", wr_count, writes);
  finish_test("write then read hit", errors_before);
endtask

task automatic lru_eviction_test();
  // Three lines of set 5 with tags 0, 1 and 2
  addr_t line_a, line_b, line_c;
  int    errors_before, writes, latency;
  errors_before = error_count;
  line_a = 32'h0000_0054;
  line_b = 32'h0000_00d8;
  line_c = 32'h0000_015c;
  store_word(line_a, 32'h1111_aaaa);
  store_word(line_b, 32'h2222_bbbb);
  writes = wr_count;
  // Both ways dirty, A is the older one
  store_word(line_c, 32'h3333_cccc);
  compare_value("memory writes", wr_count, writes + 1);
  compare_value("evicted address", last_wr_addr, 32'h0000_0050);
  compare_value("evicted line", last_wr_line, ref_line(line_a));
  writes = wr_count;
  // B is now least recently used
  load_word(line_a, latency);
  compare_value("memory writes", wr_count, writes + 1);
  compare_value("evicted address", last_wr_addr, 32'h0000_00d0);
  compare_value("evicted line", last_wr_line, ref_line(line_b));
  load_word(line_c, latency);
  load_word(line_b, latency);
  finish_test("LRU eviction", errors_before);
endtask

task automatic backpressure_test();
  addr_t addr;
  addr_t held_addr;
  word_t held_data;
  int    errors_before;
  errors_before = error_count;
  addr          = 32'h0000_0264;
  memreq_rdy    = 1'b0;
  cacheresp_rdy = 1'b0;
  send_request(1'b0, addr, 32'h0);
  do @(negedge clk); while (!memreq_val);
  held_addr = memreq_addr;
  compare_value("memreq_addr", held_addr, 32'h0000_0260);
  repeat (4) begin
    @(negedge clk);
    compare_value("memreq_val", memreq_val, 1'b1);
    compare_value("memreq_write", memreq_write, 1'b0);
    compare_value("memreq_addr", memreq_addr, held_addr);
  end
  @(posedge clk);
  #10;
  memreq_rdy = 1'b1;
  do @(negedge clk); while (!cacheresp_val);
  held_data = cacheresp_data;
  compare_value("cacheresp_data", held_data, ref_mem[addr[11:2]]);
  repeat (4) begin
    @(negedge clk);
    compare_value("cacheresp_val", cacheresp_val, 1'b1);
    compare_value("cacheresp_data", cacheresp_data, held_data);
  end
  @(posedge clk);
  #10;
  cacheresp_rdy = 1'b1;
  @(posedge clk);
  @(negedge clk);
  compare_value("cacheresp_val", cacheresp_val, 1'b0);
  @(posedge clk);
  #10;
  finish_test("back-pressure", errors_before);
endtask

task automatic random_test();
  logic        written [256];
  logic [31:0] value;
  addr_t       addr;
  int          errors_before, latency;
  errors_before = error_count;
  for (int i = 0; i < 256; i++) begin
    written[i] = 1'b0;
  end
  for (int i = 0; i < 200; i++) begin
    value = next_random();
    // Word address in the lowest 1 KB
    addr  = {22'h0, value[17:10], 2'b00};
    if (value[31]) begin
      store_word(addr, next_random());
      written[addr[9:2]] = 1'b1;
    end else begin
      load_word(addr, latency);
    end
  end
  for (int i = 0; i < 256; i++) begin
    if (written[i]) load_word(addr_t'(i * 4), latency);
  end
  finish_test("random accesses", errors_before);
endtask

// File: verification/cache_tb.sv
//--------------------------------------------------------------------
// Cache testbench: clock, reset, memory model, value checks, LCG,
// timeout and closing summary
//--------------------------------------------------------------------

`timescale 1ns/100ps

module cache_tb import cache_pkg::*; ();

  // About 460 accesses at under 20 cycles each for the random test,
  // plus the short directed tests, with a wide margin
  localparam int MAX_CYCLES = 20000;

  logic        clk;
  logic        reset;
  logic        cachereq_val, cachereq_rdy, cachereq_write;
  addr_t       cachereq_addr, memreq_addr;
  word_t       cachereq_data, cacheresp_data;
  logic        cacheresp_val, cacheresp_rdy;
  logic        memreq_val, memreq_rdy, memreq_write;
  line_t       memreq_data, memresp_data;
  logic        memresp_val, memresp_rdy;

  // Backing store and the expected contents, 4 KB each
  word_t       mem [1024];
  word_t       ref_mem [1024];
  int          rd_count, wr_count, cycle_count;
  int          test_count, check_count, error_count;
  addr_t       last_wr_addr;
  line_t       last_wr_line;
  logic [31:0] lcg_state = 32'hb0202a24;

  blocking_cache uut (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic compare_value(input string name, input logic [127:0] actual,
                               input logic [127:0] expected);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("[ERROR] %0t ns: %s = %0h, expected %0h", $time, name, actual, expected);
    end
  endtask

  // Line as the reference words say it should be
  function automatic line_t ref_line(input addr_t addr);
    line_t line;
    for (int w = 0; w < 4; w++) begin
      line[w*32 +: 32] = ref_mem[{addr[11:4], w[1:0]}];
    end
    return line;
  endfunction

  //--------------------------------------------------------------------
  // Memory model
  //--------------------------------------------------------------------

  initial begin : memory_model
    addr_t addr;
    logic  is_write;
    line_t line;
    forever begin
      @(negedge clk);
      if (!reset && memreq_val && memreq_rdy) begin
        addr     = memreq_addr;
        is_write = memreq_write;
        line     = memreq_data;
        compare_value("memreq_addr[3:0]", addr[3:0], 4'h0);
        // Transfer edge, then two cycles to answer
        repeat (3) @(posedge clk);
        #10;
        for (int w = 0; w < 4; w++) begin
          if (is_write) mem[{addr[11:4], w[1:0]}] = line[w*32 +: 32];
          else memresp_data[w*32 +: 32] = mem[{addr[11:4], w[1:0]}];
        end
        if (is_write) begin
          wr_count++;
          last_wr_addr = addr;
          last_wr_line = line;
        end else begin
          rd_count++;
        end
        memresp_val = 1'b1;
        do @(negedge clk); while (!memresp_rdy);
        @(posedge clk);
        #10;
        memresp_val = 1'b0;
      end
    end
  end

  initial begin : watchdog
    cycle_count = 0;
    while (cycle_count < MAX_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout: the run did not end within %0d cycles", MAX_CYCLES);
    $display("Something failed");
    $finish;
  end

  `include "cache_tests.svh"

  initial begin
    reset          = 1'b1;
    cachereq_val   = 1'b0;
    cachereq_write = 1'b0;
    cachereq_addr  = '0;
    cachereq_data  = '0;
    cacheresp_rdy  = 1'b1;
    memreq_rdy     = 1'b1;
    memresp_val    = 1'b0;
    memresp_data   = '0;
    // Fill word built from the whole byte address
    for (int i = 0; i < 1024; i++) begin
      mem[i]     = 32'(i * 4) * 32'h0001_0001 ^ 32'hc3a5_0000;
      ref_mem[i] = mem[i];
    end
    repeat (8) @(posedge clk);
    #10;
    reset = 1'b0;
    reset_and_miss_test();
    write_read_hit_test();
    lru_eviction_test();
    backpressure_test();
    random_test();
    $display("Tests: %0d, checks: %0d, errors: %0d", test_count, check_count, error_count);
    if (error_count == 0) $display("Everything OK");
    else $display("Something failed");
    $finish;
  end

endmodule

// File: src.f
+incdir+design
+incdir+verification
design/cache_pkg.sv
design/cache_ctrl.sv
design/cache_lookup.sv
design/cache_data_array.sv
design/blocking_cache.sv
verification/cache_tb.sv
